//--- logic/mem_noc_defs.svh
`ifndef MEM_NOC_DEFS_SVH
`define MEM_NOC_DEFS_SVH

// Network link geometry.
`define MEM_NOC_FLIT_W 16
`define MEM_NOC_CORD_W 4
`define MEM_NOC_CID_W  2

// Flits after the first one, a 3-bit field on the wire.
`define MEM_NOC_LEN_W  3

// Memory response fields.
`define MEM_ADDR_W     20
`define MEM_DATA_W     64
`define MEM_ID_W       4

// Configuration port.
`define APB_ADDR_W     4
`define APB_DATA_W     32

// Register offsets.
`define MEM_NOC_REG_CTRL  4'h0
`define MEM_NOC_REG_COORD 4'h4
`define MEM_NOC_REG_SENT  4'h8
`define MEM_NOC_REG_DROP  4'hC

// Longest packet: 6 flits after the header flit.
`define MEM_NOC_MAX_LEN   6

`endif

//--- logic/mem_noc_pkg.sv
`include "mem_noc_defs.svh"

package mem_noc_pkg;

  typedef logic [`MEM_NOC_CORD_W-1:0] cord_t;
  typedef logic [`MEM_NOC_CID_W-1:0]  cid_t;
  typedef logic [`MEM_NOC_LEN_W-1:0]  len_t;
  typedef logic [`MEM_NOC_FLIT_W-1:0] flit_t;
  typedef logic [`MEM_ADDR_W-1:0]     mem_addr_t;
  typedef logic [`MEM_DATA_W-1:0]     mem_data_t;

  // Codes 5 to 7 are not defined and get dropped.
  typedef enum logic [2:0] {
    e_mem_rd    = 3'd0,
    e_mem_wr    = 3'd1,
    e_mem_uc_rd = 3'd2,
    e_mem_uc_wr = 3'd3,
    e_mem_pre   = 3'd4
  } mem_msg_type_e;

  typedef enum logic [1:0] {
    e_size_1 = 2'd0,
    e_size_2 = 2'd1,
    e_size_4 = 2'd2,
    e_size_8 = 2'd3
  } mem_msg_size_e;

  typedef struct packed {
    mem_msg_type_e          msg_type;
    mem_msg_size_e          size;
    mem_addr_t              addr;
    logic [`MEM_ID_W-1:0]   payload_id;
  } mem_resp_hdr_s;

  typedef struct packed {
    mem_data_t     data;
    mem_resp_hdr_s header;
  } mem_resp_s;

  // Declared MSB first, so cord sits in the lowest bits.
  typedef struct packed {
    mem_data_t     data;
    mem_resp_hdr_s msg;
    cid_t          src_cid;
    cord_t         src_cord;
    len_t          len;
    cid_t          cid;
    cord_t         cord;
  } mem_resp_packet_s;

  typedef struct packed {
    cord_t src_cord;
    cid_t  src_cid;
    cord_t dst_cord;
    cid_t  dst_cid;
  } coord_cfg_s;

  typedef enum logic {
    e_idle,
    e_send
  } ser_state_e;

endpackage

//--- logic/mem_resp_packet_encode.sv
`timescale 1ns/1ps
`include "mem_noc_defs.svh"

module mem_resp_packet_encode
  import mem_noc_pkg::*;
(
  input  mem_resp_s        mem_resp_i,
  input  coord_cfg_s       coord_i,
  output mem_resp_packet_s packet_o,
  output logic             packet_valid_o
);

  localparam int FLIT_W   = `MEM_NOC_FLIT_W;
  localparam int HDR_BITS = $bits(mem_resp_packet_s) - $bits(mem_data_t);

  // Flits after the first for a packet carrying the given payload.
  function automatic int pkt_len(int payload_bits);
    return (HDR_BITS + payload_bits + FLIT_W - 1) / FLIT_W - 1;
  endfunction

  localparam len_t ACK_LEN    = len_t'(pkt_len(0));
  localparam len_t DATA_LEN_1 = len_t'(pkt_len(8 * 1));
  localparam len_t DATA_LEN_2 = len_t'(pkt_len(8 * 2));
  localparam len_t DATA_LEN_4 = len_t'(pkt_len(8 * 4));
  localparam len_t DATA_LEN_8 = len_t'(pkt_len(8 * 8));

  len_t data_len;

  always_comb begin
    case (mem_resp_i.header.size)
      e_size_1: data_len = DATA_LEN_1;
      e_size_2: data_len = DATA_LEN_2;
      e_size_4: data_len = DATA_LEN_4;
      default:  data_len = DATA_LEN_8;
    endcase
  end

  always_comb begin
    packet_o       = '0;
    packet_valid_o = 1'b1;

    packet_o.cord     = coord_i.dst_cord;
    packet_o.cid      = coord_i.dst_cid;
    packet_o.src_cord = coord_i.src_cord;
    packet_o.src_cid  = coord_i.src_cid;
    packet_o.msg      = mem_resp_i.header;
    // Whole data field goes in; the serializer trims by len.
    packet_o.data     = mem_resp_i.data;

    case (mem_resp_i.header.msg_type)
      e_mem_rd,
      e_mem_uc_rd: packet_o.len = data_len;
      e_mem_wr,
      e_mem_uc_wr,
      e_mem_pre:   packet_o.len = ACK_LEN;
      default: begin
        packet_o       = '0;
        packet_valid_o = 1'b0;
      end
    endcase
  end

  // The serializer index range stops at the longest packet.
  always_comb begin
    if (!$isunknown(packet_o.len)) begin
      len_max_a: assert (packet_o.len <= len_t'(`MEM_NOC_MAX_LEN))
        else $error("packet length %0d above maximum", packet_o.len);
    end
  end

endmodule

//--- logic/wormhole_flit_serializer.sv
`timescale 1ns/1ps
`include "mem_noc_defs.svh"

module wormhole_flit_serializer
  import mem_noc_pkg::*;
(
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             enable_i,
  input  mem_resp_packet_s packet_i,
  input  logic             packet_valid_i,
  input  logic             resp_v_i,
  output logic             resp_ready_o,
  output flit_t            link_data_o,
  output logic             link_v_o,
  input  logic             link_ready_i,
  output logic             sent_o,
  output logic             dropped_o
);

  localparam int FLIT_W    = `MEM_NOC_FLIT_W;
  localparam int PKT_W     = $bits(mem_resp_packet_s);
  localparam int NUM_FLITS = (PKT_W + FLIT_W - 1) / FLIT_W;

  ser_state_e                    state_q;
  len_t                          idx_q;
  logic                          sent_q;
  logic                          drop_q;
  mem_resp_packet_s              pkt_q;
  logic [NUM_FLITS*FLIT_W-1:0]   pkt_pad;
  logic                          accept;
  logic                          last_flit;

  assign resp_ready_o = (state_q == e_idle) && enable_i;
  assign accept       = resp_v_i && resp_ready_o;

  // Top flit is partly padding.
  assign pkt_pad     = (NUM_FLITS*FLIT_W)'(pkt_q);
  assign link_data_o = pkt_pad[idx_q*FLIT_W +: FLIT_W];
  assign link_v_o    = (state_q == e_send);
  assign last_flit   = (idx_q == pkt_q.len);

  assign sent_o    = sent_q;
  assign dropped_o = drop_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= e_idle;
      idx_q   <= '0;
      sent_q  <= 1'b0;
      drop_q  <= 1'b0;
    end else begin
      sent_q <= 1'b0;
      drop_q <= 1'b0;
      case (state_q)
        e_idle: begin
          if (accept && packet_valid_i) begin
            state_q <= e_send;
            idx_q   <= '0;
          end else if (accept) begin
            drop_q <= 1'b1;
          end
        end
        e_send: begin
          if (link_ready_i && last_flit) begin
            state_q <= e_idle;
            sent_q  <= 1'b1;
          end else if (link_ready_i) begin
            idx_q <= idx_q + len_t'(1);
          end
        end
        default: state_q <= e_idle;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      pkt_q <= packet_i;
    end
  end

  data_stable_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    link_v_o && !link_ready_i |=> link_v_o && $stable(link_data_o));

  // The flit index never runs past the stored length.
  idx_range_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    link_v_o |-> idx_q <= pkt_q.len);

endmodule

//--- logic/mem_noc_cfg_apb.sv
`timescale 1ns/1ps
`include "mem_noc_defs.svh"

module mem_noc_cfg_apb
  import mem_noc_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   psel_i,
  input  logic                   penable_i,
  input  logic                   pwrite_i,
  input  logic [`APB_ADDR_W-1:0] paddr_i,
  input  logic [`APB_DATA_W-1:0] pwdata_i,
  output logic [`APB_DATA_W-1:0] prdata_o,
  output logic                   pready_o,
  output logic                   pslverr_o,
  input  logic                   sent_i,
  input  logic                   dropped_i,
  output logic                   enable_o,
  output coord_cfg_s             coord_o
);

  logic                   enable_q;
  coord_cfg_s             coord_q;
  logic [`APB_DATA_W-1:0] sent_cnt_q;
  logic [`APB_DATA_W-1:0] drop_cnt_q;
  logic                   aligned;
  logic                   access;
  logic                   wr_en;

  assign aligned = (paddr_i[1:0] == 2'b00);
  assign access  = psel_i && penable_i;
  assign wr_en   = access && pwrite_i && aligned;

  // No wait states.
  assign pready_o  = 1'b1;
  assign pslverr_o = access && !aligned;

  assign enable_o = enable_q;
  assign coord_o  = coord_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      enable_q <= 1'b0;
      coord_q  <= '0;
    end else if (wr_en) begin
      case (paddr_i)
        `MEM_NOC_REG_CTRL: enable_q <= pwdata_i[0];
        `MEM_NOC_REG_COORD: begin
          coord_q.src_cord <= pwdata_i[3:0];
          coord_q.src_cid  <= pwdata_i[5:4];
          coord_q.dst_cord <= pwdata_i[11:8];
          coord_q.dst_cid  <= pwdata_i[13:12];
        end
        // SENT and DROP are read only.
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sent_cnt_q <= '0;
      drop_cnt_q <= '0;
    end else begin
      if (sent_i) begin
        sent_cnt_q <= sent_cnt_q + 32'd1;
      end
      if (dropped_i) begin
        drop_cnt_q <= drop_cnt_q + 32'd1;
      end
    end
  end

  always_comb begin
    prdata_o = '0;
    case (paddr_i)
      `MEM_NOC_REG_CTRL:  prdata_o[0] = enable_q;
      `MEM_NOC_REG_COORD: begin
        prdata_o[3:0]   = coord_q.src_cord;
        prdata_o[5:4]   = coord_q.src_cid;
        prdata_o[11:8]  = coord_q.dst_cord;
        prdata_o[13:12] = coord_q.dst_cid;
      end
      `MEM_NOC_REG_SENT:  prdata_o = sent_cnt_q;
      `MEM_NOC_REG_DROP:  prdata_o = drop_cnt_q;
      default:            prdata_o = '0;
    endcase
  end

  // Master side protocol: the access phase only follows a select.
  penable_psel_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    penable_i |-> psel_i);

endmodule

//--- logic/mem_resp_noc_out.sv
`timescale 1ns/1ps
`include "mem_noc_defs.svh"

module mem_resp_noc_out
  import mem_noc_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  mem_resp_s              mem_resp_i,
  input  logic                   mem_resp_v_i,
  output logic                   mem_resp_ready_o,
  output flit_t                  link_data_o,
  output logic                   link_v_o,
  input  logic                   link_ready_i,
  input  logic                   psel_i,
  input  logic                   penable_i,
  input  logic                   pwrite_i,
  input  logic [`APB_ADDR_W-1:0] paddr_i,
  input  logic [`APB_DATA_W-1:0] pwdata_i,
  output logic [`APB_DATA_W-1:0] prdata_o,
  output logic                   pready_o,
  output logic                   pslverr_o
);

  coord_cfg_s       coord;
  logic             enable;
  mem_resp_packet_s packet;
  logic             packet_valid;
  logic             sent;
  logic             dropped;

  mem_resp_packet_encode u_encode (
    .mem_resp_i     (mem_resp_i),
    .coord_i        (coord),
    .packet_o       (packet),
    .packet_valid_o (packet_valid)
  );

  wormhole_flit_serializer u_serializer (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .enable_i       (enable),
    .packet_i       (packet),
    .packet_valid_i (packet_valid),
    .resp_v_i       (mem_resp_v_i),
    .resp_ready_o   (mem_resp_ready_o),
    .link_data_o    (link_data_o),
    .link_v_o       (link_v_o),
    .link_ready_i   (link_ready_i),
    .sent_o         (sent),
    .dropped_o      (dropped)
  );

  // Configuration sits beside the serializer it steers.
  mem_noc_cfg_apb u_cfg (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pwrite_i  (pwrite_i),
    .paddr_i   (paddr_i),
    .pwdata_i  (pwdata_i),
    .prdata_o  (prdata_o),
    .pready_o  (pready_o),
    .pslverr_o (pslverr_o),
    .sent_i    (sent),
    .dropped_i (dropped),
    .enable_o  (enable),
    .coord_o   (coord)
  );

endmodule

//--- bench/mem_resp_noc_out_tb.sv
`timescale 1ns/1ps
`include "mem_noc_defs.svh"

module mem_resp_noc_out_tb
  import mem_noc_pkg::*;
();

  localparam int NUM_ACK  = 20;
  localparam int NUM_RD   = 16;
  localparam int NUM_RAND = 164;
  // Up to 7 flits at half link rate plus register traffic stays well under 100 cycles a packet.
  localparam int TIMEOUT_CYC = (NUM_ACK + NUM_RD + NUM_RAND) * 100;

  logic                   clk_i;
  logic                   rst_n_i;
  mem_resp_s              mem_resp_i;
  logic                   mem_resp_v_i;
  logic                   mem_resp_ready_o;
  flit_t                  link_data_o;
  logic                   link_v_o;
  logic                   link_ready_i;
  logic                   psel_i;
  logic                   penable_i;
  logic                   pwrite_i;
  logic [`APB_ADDR_W-1:0] paddr_i;
  logic [`APB_DATA_W-1:0] pwdata_i;
  logic [`APB_DATA_W-1:0] prdata_o;
  logic                   pready_o;
  logic                   pslverr_o;

  integer      seed;
  int          cycles;
  int          exp_sent;
  int          exp_drop;
  flit_t       exp_q[$];
  logic [31:0] coord_w;
  logic        bp_en;
  logic [31:0] bp_r;

  mem_resp_noc_out UUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  function automatic logic [31:0] rnd();
    return $random(seed);
  endfunction

  // Flits after the header flit for 44 bits of routing and header plus the payload.
  function automatic int model_len(logic [2:0] t, logic [1:0] s);
    int payload;
    payload = 0;
    if (t == 3'd0 || t == 3'd2) begin
      payload = 8 * (1 << s);
    end
    return (44 + payload + 15) / 16 - 1;
  endfunction

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("[ERROR] t=%0t %s got=%0h exp=%0h", $time, name, got, exp);
      $display("STATUS: FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  // No wait states and an error only for unaligned addresses.
  task automatic check_apb_resp(input logic [3:0] addr);
    check_val("pready_o", 64'(pready_o), 64'(1));
    check_val("pslverr_o", 64'(pslverr_o), 64'(addr[1:0] != 2'b00));
  endtask

  task automatic expect_resp(input logic [2:0] t, input logic [1:0] s, input logic [19:0] addr,
                             input logic [3:0] id, input logic [63:0] data);
    logic [111:0] pkt;
    int           len;
    if (t > 3'd4) begin
      exp_drop++;
    end else begin
      len = model_len(t, s);
      pkt = {4'b0, data, t, s, addr, id, coord_w[5:4], coord_w[3:0], 3'(len),
             coord_w[13:12], coord_w[11:8]};
      for (int i = 0; i <= len; i++) begin
        exp_q.push_back(pkt[i*16 +: 16]);
      end
      exp_sent++;
    end
  endtask

  task automatic send_resp(input logic [2:0] t, input logic [1:0] s);
    logic [31:0] r;
    logic [63:0] data;
    r = rnd();
    data = {rnd(), rnd()};
    mem_resp_i.header.msg_type   = mem_msg_type_e'(t);
    mem_resp_i.header.size       = mem_msg_size_e'(s);
    mem_resp_i.header.addr       = r[19:0];
    mem_resp_i.header.payload_id = r[23:20];
    mem_resp_i.data              = data;
    mem_resp_v_i = 1'b1;
    forever begin
      @(negedge clk_i);
      if (mem_resp_ready_o) break;
    end
    @(posedge clk_i);
    expect_resp(t, s, r[19:0], r[23:20], data);
    #1;
    mem_resp_v_i = 1'b0;
  endtask

  task automatic apb_write(input logic [3:0] addr, input logic [31:0] data);
    psel_i   = 1'b1;
    pwrite_i = 1'b1;
    paddr_i  = addr;
    pwdata_i = data;
    @(posedge clk_i);
    #1;
    penable_i = 1'b1;
    @(negedge clk_i);
    check_apb_resp(addr);
    @(posedge clk_i);
    #1;
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
  endtask

  task automatic apb_read(input logic [3:0] addr, output logic [31:0] data);
    psel_i   = 1'b1;
    pwrite_i = 1'b0;
    paddr_i  = addr;
    @(posedge clk_i);
    #1;
    penable_i = 1'b1;
    @(negedge clk_i);
    data = prdata_o;
    check_apb_resp(addr);
    @(posedge clk_i);
    #1;
    psel_i    = 1'b0;
    penable_i = 1'b0;
  endtask

  task automatic check_reg(input string name, input logic [3:0] addr, input logic [31:0] exp);
    logic [31:0] rd;
    apb_read(addr, rd);
    check_val(name, 64'(rd), 64'(exp));
  endtask

  // Link back-pressure is random once enabled.
  always @(posedge clk_i) begin
    #1;
    bp_r = rnd();
    link_ready_i = bp_en ? bp_r[0] : 1'b1;
  end

  // A flit moves at the next rising edge when valid and ready are high here.
  always @(negedge clk_i) begin
    if (rst_n_i && link_v_o && link_ready_i) begin
      if (exp_q.size() == 0) begin
        $display("A flit was sent on the link while no packet was outstanding");
        $display("STATUS: FAIL");
        $fatal(1, "unexpected flit");
      end else begin
        check_val("link_data_o", 64'(link_data_o), 64'(exp_q.pop_front()));
      end
    end
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= TIMEOUT_CYC) begin
      $display("Timeout: the test did not finish within %0d cycles", TIMEOUT_CYC);
      $display("STATUS: FAIL");
      $fatal(1, "timeout");
    end
  end

  initial begin
    logic [31:0] r;
    seed         = 32'h1826_51bf;
    cycles       = 0;
    exp_sent     = 0;
    exp_drop     = 0;
    coord_w      = '0;
    bp_en        = 1'b0;
    rst_n_i      = 1'b0;
    mem_resp_i   = '0;
    mem_resp_v_i = 1'b0;
    link_ready_i = 1'b1;
    psel_i       = 1'b0;
    penable_i    = 1'b0;
    pwrite_i     = 1'b0;
    paddr_i      = '0;
    pwdata_i     = '0;
    repeat (3) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;

    check_reg("CTRL", `MEM_NOC_REG_CTRL, 32'd0);
    check_reg("COORD", `MEM_NOC_REG_COORD, 32'd0);
    check_reg("SENT", `MEM_NOC_REG_SENT, 32'd0);
    check_reg("DROP", `MEM_NOC_REG_DROP, 32'd0);
    // A pending response must wait while disabled.
    mem_resp_v_i = 1'b1;
    repeat (4) begin
      @(negedge clk_i);
      check_val("mem_resp_ready_o", 64'(mem_resp_ready_o), 64'(0));
    end
    @(posedge clk_i);
    #1;
    mem_resp_v_i = 1'b0;

    r = rnd();
    apb_write(`MEM_NOC_REG_COORD, r);
    coord_w = r;
    apb_write(`MEM_NOC_REG_CTRL, 32'd1);
    check_reg("COORD", `MEM_NOC_REG_COORD, r & 32'h0000_3F3F);
    // An unaligned write is refused and leaves CTRL set.
    apb_write(4'h1, 32'd0);
    check_reg("CTRL", `MEM_NOC_REG_CTRL, 32'd1);

    repeat (NUM_ACK) begin
      r = rnd();
      case (r[1:0])
        2'd0:    send_resp(3'd1, r[3:2]);
        2'd1:    send_resp(3'd3, r[3:2]);
        default: send_resp(3'd4, r[3:2]);
      endcase
    end
    for (int i = 0; i < NUM_RD; i++) begin
      send_resp(i[0] ? 3'd2 : 3'd0, i[3:2]);
    end

    // Mixed traffic with drops and coordinate writes while a packet is in flight.
    bp_en = 1'b1;
    repeat (NUM_RAND) begin
      r = rnd();
      send_resp(r[2:0], r[4:3]);
      if (r[7:5] == 3'd0) begin
        r = rnd();
        apb_write(`MEM_NOC_REG_COORD, r);
        coord_w = r;
      end
    end

    while (exp_q.size() != 0) @(negedge clk_i);
    repeat (3) @(posedge clk_i);
    #1;
    check_val("link_v_o", 64'(link_v_o), 64'(0));
    check_reg("SENT", `MEM_NOC_REG_SENT, exp_sent);
    check_reg("DROP", `MEM_NOC_REG_DROP, exp_drop);
    apb_write(`MEM_NOC_REG_SENT, rnd());
    check_reg("SENT", `MEM_NOC_REG_SENT, exp_sent);

    $display("STATUS: PASS");
    $finish;
  end

endmodule

//--- all.f
+incdir+logic
logic/mem_noc_pkg.sv
logic/mem_resp_packet_encode.sv
logic/wormhole_flit_serializer.sv
logic/mem_noc_cfg_apb.sv
logic/mem_resp_noc_out.sv
bench/mem_resp_noc_out_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator; the exit status carries pass or fail.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f all.f \
  --top-module mem_resp_noc_out_tb --Mdir obj_dir -o sim &&
./obj_dir/sim ||
{ echo "simulation failed"; exit 1; }
